//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_router
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
router_pkg.sv
input_queue.sv
route_stage.sv
switch_alloc.sv
credit_link.sv
router.sv
tb_router.sv

//--- credit_link.sv
`timescale 1ns/10ps
`default_nettype none

module credit_link #(
    parameter int QUEUE_DEPTH = 16,
    parameter int CREDIT_PERIOD = 32,
    parameter int CREDIT_THRESHOLD = 4
) (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire router_pkg::port_flit_t            in [router_pkg::NUM_PORTS],
    input  wire [$clog2(QUEUE_DEPTH + 1) - 1:0]    used [router_pkg::NUM_PORTS],
    input  wire router_pkg::port_flit_t            sw_out [router_pkg::NUM_PORTS],
    output logic [router_pkg::NUM_PORTS - 1:0]     out_ready,
    output router_pkg::port_flit_t                 out [router_pkg::NUM_PORTS]
);

    localparam int NP = router_pkg::NUM_PORTS;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);
    localparam int TW = (CREDIT_PERIOD > 1) ? $clog2(CREDIT_PERIOD) : 1;

    logic [CW - 1:0]   credits [NP];
    logic [TW - 1:0]   period_cnt;
    logic              credit_slot;
    router_pkg::flit_t credit_flit [NP];

    // last cycle of the period is reserved for credit flits
    assign credit_slot = (period_cnt == TW'(CREDIT_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            period_cnt <= '0;
        end else if (credit_slot) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // downstream free space as last reported
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NP; p++) begin
                credits[p] <= CW'(QUEUE_DEPTH);
            end
        end else begin
            for (int p = 0; p < NP; p++) begin
                if (in[p].valid && (in[p].flit.kind == router_pkg::FLIT_CREDIT)) begin
                    credits[p] <= in[p].flit.payload[CW - 1:0];
                end
            end
        end
    end

    always_comb begin
        for (int q = 0; q < NP; q++) begin
            out_ready[q] = (int'(credits[q]) >= CREDIT_THRESHOLD) && !credit_slot;
            credit_flit[q].kind = router_pkg::FLIT_CREDIT;
            credit_flit[q].dst_x = '0;
            credit_flit[q].dst_y = '0;
            credit_flit[q].dst_z = '0;
            // free slots of the input queue on the same side
            credit_flit[q].payload = router_pkg::PAYLOAD_W'(CW'(QUEUE_DEPTH) - used[q]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int q = 0; q < NP; q++) begin
                out[q].valid <= 1'b0;
            end
        end else begin
            for (int q = 0; q < NP; q++) begin
                if (credit_slot) begin
                    out[q].valid <= 1'b1;
                    out[q].flit <= credit_flit[q];
                end else begin
                    out[q] <= sw_out[q];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- input_queue.sv
`timescale 1ns/10ps
`default_nettype none

module input_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    push,
    input  wire router_pkg::flit_t                 push_flit,
    input  wire                                    pop,
    output router_pkg::flit_t                      head,
    output logic                                   not_empty,
    output logic [$clog2(QUEUE_DEPTH + 1) - 1:0]   used
);

    localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    router_pkg::flit_t mem [QUEUE_DEPTH];
    logic [AW - 1:0] rd_ptr;
    logic [AW - 1:0] wr_ptr;
    logic [CW - 1:0] count;
    logic            do_push;
    logic            do_pop;

    function automatic logic [AW - 1:0] next_ptr(input logic [AW - 1:0] ptr);
        return (ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // full queue drops the push, credits keep this from happening
    assign do_push = push && (count != CW'(QUEUE_DEPTH));
    assign do_pop = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    // first word falls through
    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign used = count;

endmodule

`default_nettype wire

//--- route_stage.sv
`timescale 1ns/10ps
`default_nettype none

module route_stage #(
    parameter logic [router_pkg::COORD_W - 1:0] cur_x = '0,
    parameter logic [router_pkg::COORD_W - 1:0] cur_y = '0,
    parameter logic [router_pkg::COORD_W - 1:0] cur_z = '0
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire router_pkg::flit_t     head,
    input  wire                        not_empty,
    input  wire                        grant,
    output logic                       pop,
    output router_pkg::routed_t        routed,
    output router_pkg::port_flit_t     eject
);

    router_pkg::routed_t slot;
    router_pkg::routed_t next_slot;
    logic                free;

    // dimension order, x then y then z
    always_comb begin
        next_slot.valid = 1'b1;
        next_slot.flit = head;
        next_slot.eject = 1'b0;
        if (head.dst_x > cur_x) begin
            next_slot.out_dir = router_pkg::DIR_XPOS;
        end else if (head.dst_x < cur_x) begin
            next_slot.out_dir = router_pkg::DIR_XNEG;
        end else if (head.dst_y > cur_y) begin
            next_slot.out_dir = router_pkg::DIR_YPOS;
        end else if (head.dst_y < cur_y) begin
            next_slot.out_dir = router_pkg::DIR_YNEG;
        end else if (head.dst_z > cur_z) begin
            next_slot.out_dir = router_pkg::DIR_ZPOS;
        end else if (head.dst_z < cur_z) begin
            next_slot.out_dir = router_pkg::DIR_ZNEG;
        end else begin
            // addressed to this router
            next_slot.out_dir = router_pkg::DIR_XPOS;
            next_slot.eject = 1'b1;
        end
    end

    // eject never waits
    assign free = slot.valid && (slot.eject || grant);
    assign pop = not_empty && (!slot.valid || free);

    always_ff @(posedge clk) begin
        if (rst) begin
            slot.valid <= 1'b0;
        end else if (pop) begin
            slot <= next_slot;
        end else if (free) begin
            slot.valid <= 1'b0;
        end
    end

    assign routed = slot;
    assign eject.valid = slot.valid && slot.eject;
    assign eject.flit = slot.flit;

endmodule

`default_nettype wire

//--- router.sv
`timescale 1ns/10ps
`default_nettype none

module router #(
    parameter logic [router_pkg::COORD_W - 1:0] cur_x = '0,
    parameter logic [router_pkg::COORD_W - 1:0] cur_y = '0,
    parameter logic [router_pkg::COORD_W - 1:0] cur_z = '0,
    parameter int QUEUE_DEPTH = 16,
    parameter int CREDIT_PERIOD = 32,
    parameter int CREDIT_THRESHOLD = 4
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire router_pkg::port_flit_t    in [router_pkg::NUM_PORTS],
    output router_pkg::port_flit_t         out [router_pkg::NUM_PORTS],
    output router_pkg::port_flit_t         eject [router_pkg::NUM_PORTS]
);

    localparam int NP = router_pkg::NUM_PORTS;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    router_pkg::flit_t      head [NP];
    logic [CW - 1:0]        used [NP];
    router_pkg::routed_t    routed [NP];
    router_pkg::port_flit_t sw_out [NP];
    logic [NP - 1:0]        push;
    logic [NP - 1:0]        not_empty;
    logic [NP - 1:0]        pop;
    logic [NP - 1:0]        grant;
    logic [NP - 1:0]        out_ready;

    for (genvar p = 0; p < NP; p++) begin : g_port
        // credit flits go to credit_link, everything else is queued
        assign push[p] = in[p].valid && (in[p].flit.kind != router_pkg::FLIT_CREDIT);

        input_queue #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) queue_inst (
            .clk       (clk),
            .rst       (rst),
            .push      (push[p]),
            .push_flit (in[p].flit),
            .pop       (pop[p]),
            .head      (head[p]),
            .not_empty (not_empty[p]),
            .used      (used[p])
        );

        route_stage #(
            .cur_x(cur_x),
            .cur_y(cur_y),
            .cur_z(cur_z)
        ) route_inst (
            .clk       (clk),
            .rst       (rst),
            .head      (head[p]),
            .not_empty (not_empty[p]),
            .grant     (grant[p]),
            .pop       (pop[p]),
            .routed    (routed[p]),
            .eject     (eject[p])
        );
    end

    switch_alloc alloc_inst (
        .clk       (clk),
        .rst       (rst),
        .routed    (routed),
        .out_ready (out_ready),
        .grant     (grant),
        .sw_out    (sw_out)
    );

    credit_link #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .CREDIT_PERIOD   (CREDIT_PERIOD),
        .CREDIT_THRESHOLD(CREDIT_THRESHOLD)
    ) link_inst (
        .clk       (clk),
        .rst       (rst),
        .in        (in),
        .used      (used),
        .sw_out    (sw_out),
        .out_ready (out_ready),
        .out       (out)
    );

endmodule

`default_nettype wire

//--- router_pkg.sv
`default_nettype none

package router_pkg;

    localparam int NUM_PORTS = 6;
    localparam int COORD_W = 4;
    localparam int FLIT_W = 64;
    // kind field plus three coordinates
    localparam int HEADER_W = 2 + 3 * COORD_W;
    localparam int PAYLOAD_W = FLIT_W - HEADER_W;

    // also the index of every per-port array
    typedef enum logic [2:0] {
        DIR_XPOS = 3'd0,
        DIR_YPOS = 3'd1,
        DIR_ZPOS = 3'd2,
        DIR_XNEG = 3'd3,
        DIR_YNEG = 3'd4,
        DIR_ZNEG = 3'd5
    } dir_e;

    typedef enum logic [1:0] {
        FLIT_DATA   = 2'd0,
        FLIT_CREDIT = 2'd1
    } flit_kind_e;

    // credit flits carry the free-slot count in the low payload bits
    typedef struct packed {
        flit_kind_e             kind;
        logic [COORD_W - 1:0]   dst_x;
        logic [COORD_W - 1:0]   dst_y;
        logic [COORD_W - 1:0]   dst_z;
        logic [PAYLOAD_W - 1:0] payload;
    } flit_t;

    typedef struct packed {
        logic  valid;
        flit_t flit;
    } port_flit_t;

    typedef struct packed {
        logic  valid;
        flit_t flit;
        dir_e  out_dir;
        logic  eject;
    } routed_t;

endpackage

`default_nettype wire

//--- switch_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module switch_alloc (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire router_pkg::routed_t                   routed [router_pkg::NUM_PORTS],
    input  wire [router_pkg::NUM_PORTS - 1:0]          out_ready,
    output logic [router_pkg::NUM_PORTS - 1:0]         grant,
    output router_pkg::port_flit_t                     sw_out [router_pkg::NUM_PORTS]
);

    localparam int NP = router_pkg::NUM_PORTS;
    localparam int PW = $clog2(NP);

    logic [PW - 1:0] rr_ptr [NP];
    logic [PW - 1:0] winner [NP];
    logic [NP - 1:0] found;
    // req[q][i] means input i wants output q
    logic [NP - 1:0] req [NP];

    always_comb begin
        for (int q = 0; q < NP; q++) begin
            for (int i = 0; i < NP; i++) begin
                req[q][i] = routed[i].valid && !routed[i].eject &&
                            (routed[i].out_dir == router_pkg::dir_e'(q));
            end
        end
    end

    // first requester at or after the pointer wins
    always_comb begin
        int idx;
        grant = '0;
        for (int q = 0; q < NP; q++) begin
            found[q] = 1'b0;
            winner[q] = '0;
            for (int off = 0; off < NP; off++) begin
                idx = int'(rr_ptr[q]) + off;
                if (idx >= NP) begin
                    idx = idx - NP;
                end
                if (!found[q] && out_ready[q] && req[q][idx]) begin
                    found[q] = 1'b1;
                    winner[q] = PW'(idx);
                end
            end
            sw_out[q].valid = found[q];
            sw_out[q].flit = routed[winner[q]].flit;
            // an input asks for one output, so one grant at most
            if (found[q]) begin
                grant[winner[q]] = 1'b1;
            end
        end
    end

    // pointer moves just past the winner
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int q = 0; q < NP; q++) begin
                rr_ptr[q] <= '0;
            end
        end else begin
            for (int q = 0; q < NP; q++) begin
                if (found[q]) begin
                    rr_ptr[q] <= (winner[q] == PW'(NP - 1)) ? '0 : winner[q] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_router.sv
`timescale 1ns/10ps
`default_nettype none

module tb_router;

    localparam int NP = router_pkg::NUM_PORTS;
    localparam int PW = router_pkg::PAYLOAD_W;
    localparam logic [router_pkg::COORD_W - 1:0] CUR_X = 2;
    localparam logic [router_pkg::COORD_W - 1:0] CUR_Y = 2;
    localparam logic [router_pkg::COORD_W - 1:0] CUR_Z = 2;
    localparam int QUEUE_DEPTH = 16;
    localparam int CREDIT_PERIOD = 32;
    localparam int CREDIT_THRESHOLD = 4;
    // seven streams per input, one per output plus eject
    localparam int NT = NP + 1;
    localparam int EJECT = NP;
    // drive to eject, one cycle after the sampling edge
    localparam int EJECT_LAT = 2;
    localparam int N_LOCAL = 8;
    localparam int N_ROUNDS = 5;
    localparam int N_BURST = 12;
    localparam int N_HELD = 5;
    localparam int N_FAIR = 8;
    // stall test adds two credit flits, three local and two y flits
    localparam int TOTAL_FLITS = NP * N_LOCAL + N_ROUNDS * NP * N_BURST + N_HELD + 7
                                 + (NP - 1) * N_FAIR;
    localparam int MAX_CYCLES = TOTAL_FLITS * 8 + 10 * CREDIT_PERIOD;

    logic clk = 1'b0;
    logic rst;
    router_pkg::port_flit_t in_link [NP];
    router_pkg::port_flit_t out_link [NP];
    router_pkg::port_flit_t eject_link [NP];

    router_pkg::flit_t exp_q [NP * NT][$];
    int sent_q [NP * NT][$];
    logic [PW - 1:0] last_credit [NP];
    int wait_cnt [NP];
    int cyc = 0;
    int errors = 0;
    int test_base = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int credit_events = 0;
    int last_credit_cyc = -1;
    bit check_latency = 1'b0;
    bit xpos_stalled = 1'b0;
    bit fair_check = 1'b0;
    int fair_port = 0;

    router #(
        .cur_x           (CUR_X),
        .cur_y           (CUR_Y),
        .cur_z           (CUR_Z),
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .CREDIT_PERIOD   (CREDIT_PERIOD),
        .CREDIT_THRESHOLD(CREDIT_THRESHOLD)
    ) router_inst (
        .clk   (clk),
        .rst   (rst),
        .in    (in_link),
        .out   (out_link),
        .eject (eject_link)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, traffic did not drain in time", cyc);
            $display("test failed");
            $finish;
        end
    end

    // x first, then y, then z
    function automatic int expected_port(input int x, input int y, input int z);
        if (x > int'(CUR_X)) return int'(router_pkg::DIR_XPOS);
        if (x < int'(CUR_X)) return int'(router_pkg::DIR_XNEG);
        if (y > int'(CUR_Y)) return int'(router_pkg::DIR_YPOS);
        if (y < int'(CUR_Y)) return int'(router_pkg::DIR_YNEG);
        if (z > int'(CUR_Z)) return int'(router_pkg::DIR_ZPOS);
        if (z < int'(CUR_Z)) return int'(router_pkg::DIR_ZNEG);
        return EJECT;
    endfunction

    function automatic int slot(input int src, input int target);
        return src * NT + target;
    endfunction

    function automatic logic [PW - 1:0] rand_payload();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[PW - 1:0];
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
        for (int p = 0; p < NP; p++) begin
            in_link[p].valid = 1'b0;
        end
    endtask

    // data flits carry their source input in the low payload bits
    task automatic put(input int p, input router_pkg::flit_kind_e kind, input int x,
                       input int y, input int z, input logic [PW - 1:0] pl);
        router_pkg::flit_t f;
        f.kind = kind;
        f.dst_x = x[router_pkg::COORD_W - 1:0];
        f.dst_y = y[router_pkg::COORD_W - 1:0];
        f.dst_z = z[router_pkg::COORD_W - 1:0];
        f.payload = pl;
        if (kind == router_pkg::FLIT_DATA) begin
            f.payload[2:0] = p[2:0];
            exp_q[slot(p, expected_port(x, y, z))].push_back(f);
            sent_q[slot(p, expected_port(x, y, z))].push_back(cyc);
        end
        in_link[p].valid = 1'b1;
        in_link[p].flit = f;
    endtask

    task automatic match_flit(input int idx, input string sig, input router_pkg::flit_t got);
        router_pkg::flit_t want;
        int sent;
        if (exp_q[idx].size() == 0) begin
            $display("%0t: %s carried flit %h that was never sent to it", $time, sig, got);
            errors++;
        end else begin
            want = exp_q[idx].pop_front();
            sent = sent_q[idx].pop_front();
            if (got != want) begin
                $display("ERROR %0t %s: expected %h, got %h", $time, sig, want, got);
                errors++;
            end
            if (check_latency && (cyc - sent != EJECT_LAT)) begin
                $display("ERROR %0t %s latency: expected %0d, got %0d", $time, sig,
                         EJECT_LAT, cyc - sent);
                errors++;
            end
        end
    endtask

    // inputs still holding flits for this output count one more lost grant
    task automatic note_grant(input int q, input int src);
        wait_cnt[src] = 0;
        for (int t = 0; t < NP; t++) begin
            if (t != src && exp_q[slot(t, q)].size() != 0) begin
                wait_cnt[t]++;
                if (wait_cnt[t] > NP) begin
                    $display("%0t: input %0d waited more than %0d grants on out[%0d]",
                             $time, t, NP, q);
                    errors++;
                end
            end
        end
    endtask

    always @(negedge clk) begin : check_outputs
        int n_credit;
        int src;
        if (!rst) begin
            n_credit = 0;
            for (int q = 0; q < NP; q++) begin
                if (!fair_check) begin
                    wait_cnt[q] = 0;
                end
                if (out_link[q].valid && out_link[q].flit.kind == router_pkg::FLIT_CREDIT) begin
                    n_credit++;
                    last_credit[q] = out_link[q].flit.payload;
                end else if (out_link[q].valid) begin
                    src = int'(out_link[q].flit.payload[2:0]);
                    if (q == int'(router_pkg::DIR_XPOS) && xpos_stalled) begin
                        $display("%0t: data left on out[0] with downstream credits low", $time);
                        errors++;
                    end
                    if (src >= NP) begin
                        $display("%0t: out[%0d] carried a flit from no known input", $time, q);
                        errors++;
                    end else begin
                        match_flit(slot(src, q), $sformatf("out[%0d]", q), out_link[q].flit);
                        if (fair_check && q == fair_port) begin
                            note_grant(q, src);
                        end
                    end
                end
                if (eject_link[q].valid) begin
                    match_flit(slot(q, EJECT), $sformatf("eject[%0d]", q), eject_link[q].flit);
                end
            end
            if (n_credit != 0 && n_credit != NP) begin
                $display("%0t: credit flits appeared on only %0d outputs", $time, n_credit);
                errors++;
            end
            if (n_credit == NP) begin
                if (last_credit_cyc >= 0 && cyc - last_credit_cyc != CREDIT_PERIOD) begin
                    $display("ERROR %0t out credit spacing: expected %0d, got %0d", $time,
                             CREDIT_PERIOD, cyc - last_credit_cyc);
                    errors++;
                end
                last_credit_cyc = cyc;
                credit_events++;
            end
        end
    end

    task automatic wait_drain();
        int pending;
        pending = 1;
        while (pending != 0) begin
            step();
            pending = 0;
            for (int i = 0; i < NP * NT; i++) begin
                pending += exp_q[i].size();
            end
        end
        repeat (4) step();
    endtask

    task automatic wait_credit();
        int ev;
        ev = credit_events;
        while (credit_events == ev) begin
            step();
        end
    endtask

    task automatic begin_test();
        test_base = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_base) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - test_base);
        end
    endtask

    task automatic local_ejection();
        check_latency = 1'b1;
        for (int i = 0; i < N_LOCAL; i++) begin
            step();
            for (int p = 0; p < NP; p++) begin
                put(p, router_pkg::FLIT_DATA, 2, 2, 2, rand_payload());
            end
        end
        wait_drain();
        check_latency = 1'b0;
    endtask

    task automatic forwarding();
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int i = 0; i < N_BURST; i++) begin
                step();
                for (int p = 0; p < NP; p++) begin
                    put(p, router_pkg::FLIT_DATA, int'($urandom_range(3, 1)),
                        int'($urandom_range(3, 1)), int'($urandom_range(3, 1)), rand_payload());
                end
            end
            wait_drain();
        end
    endtask

    task automatic credit_emission();
        wait_credit();
        wait_credit();
        for (int q = 0; q < NP; q++) begin
            if (last_credit[q] != PW'(QUEUE_DEPTH)) begin
                $display("ERROR %0t out[%0d] credit count: expected %0d, got %0d", $time, q,
                         QUEUE_DEPTH, last_credit[q]);
                errors++;
            end
        end
    endtask

    task automatic credit_stall();
        step();
        put(router_pkg::DIR_XPOS, router_pkg::FLIT_CREDIT, 0, 0, 0, PW'(2));
        xpos_stalled = 1'b1;
        for (int i = 0; i < N_HELD; i++) begin
            step();
            put(router_pkg::DIR_XNEG, router_pkg::FLIT_DATA, 3, int'($urandom_range(3, 1)),
                int'($urandom_range(3, 1)), rand_payload());
            if (i < 3) begin
                put(router_pkg::DIR_YPOS, router_pkg::FLIT_DATA, 2, 2, 2, rand_payload());
            end
            if (i < 2) begin
                put(router_pkg::DIR_ZPOS, router_pkg::FLIT_DATA, 2, 3, 1, rand_payload());
            end
        end
        repeat (10) step();
        if (exp_q[slot(router_pkg::DIR_YPOS, EJECT)].size() != 0 ||
            exp_q[slot(router_pkg::DIR_ZPOS, router_pkg::DIR_YPOS)].size() != 0) begin
            $display("%0t: eject or y traffic stopped while xpos was stalled", $time);
            errors++;
        end
    endtask

    // one flit sits in the route register, the rest stay queued
    task automatic occupancy_report();
        wait_credit();
        if (last_credit[router_pkg::DIR_XNEG] != PW'(QUEUE_DEPTH - (N_HELD - 1))) begin
            $display("ERROR %0t out[3] credit count: expected %0d, got %0d", $time,
                     QUEUE_DEPTH - (N_HELD - 1), last_credit[router_pkg::DIR_XNEG]);
            errors++;
        end
    endtask

    task automatic credit_release();
        step();
        put(router_pkg::DIR_XPOS, router_pkg::FLIT_CREDIT, 0, 0, 0, PW'(QUEUE_DEPTH));
        xpos_stalled = 1'b0;
        wait_drain();
    endtask

    task automatic fairness();
        fair_port = int'(router_pkg::DIR_ZPOS);
        fair_check = 1'b1;
        for (int i = 0; i < N_FAIR; i++) begin
            step();
            for (int p = 0; p < NP; p++) begin
                if (p != fair_port) begin
                    put(p, router_pkg::FLIT_DATA, 2, 2, 3, rand_payload());
                end
            end
        end
        wait_drain();
        fair_check = 1'b0;
    endtask

    initial begin
        int seed_dummy;
        seed_dummy = int'($urandom(32'h028542f1));
        rst = 1'b1;
        for (int p = 0; p < NP; p++) begin
            in_link[p] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        begin_test();
        local_ejection();
        end_test("local ejection");
        begin_test();
        forwarding();
        end_test("dimension-order forwarding");
        begin_test();
        credit_emission();
        end_test("credit emission");
        begin_test();
        credit_stall();
        end_test("credit back-pressure stall");
        begin_test();
        occupancy_report();
        end_test("queue occupancy report");
        begin_test();
        credit_release();
        end_test("credit back-pressure release");
        begin_test();
        fairness();
        end_test("contention fairness");
        $display("summary: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
